// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;
    import decode_pkg::*;

    localparam int timeout_cycles = 2000; // The tests take well under 100 cycles.

    logic clock;
    logic reset;
    fetch_type fetch;
    redirect_type redirect;
    stage_info_type exec_info;
    stage_info_type mem_info;
    logic trap;
    logic backend_stall;
    writeback_type writeback;
    decode_out_type q;
    logic [31:0] rdata1;
    logic [31:0] rdata2;

    int errors = 0;
    int cycles = 0;
    logic [31:0] seed = 32'h5c96_cad2;

    decode_top decode_top_inst (
        .clock(clock), .reset(reset), .fetch(fetch), .redirect(redirect),
        .exec_info(exec_info), .mem_info(mem_info), .trap(trap),
        .backend_stall(backend_stall), .writeback(writeback),
        .q(q), .rdata1(rdata1), .rdata2(rdata2)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles.", timeout_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // Expected return hints as {push, pop, jump_uncond, jump_rest}.
    function automatic logic [3:0] expected_hints(input logic is_jal, input logic [4:0] rd,
                                                  input logic [4:0] rs);
        logic rd_link;
        logic rs_link;
        rd_link = (rd == 5'd1) || (rd == 5'd5);
        rs_link = (rs == 5'd1) || (rs == 5'd5);
        if (is_jal) begin
            if (rd_link) return 4'b1000;
            if (rd == 5'd0) return 4'b0010;
            return 4'b0001;
        end
        if (!rd_link && rs_link) return 4'b0100;
        if (rd_link && !rs_link) return 4'b1000;
        if (rd_link && rs_link) return (rd == rs) ? 4'b1000 : 4'b1100;
        return 4'b0001;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        @(negedge clock);
    endtask

    task automatic idle_inputs();
        fetch = '{pc: 32'h0, instr: 32'h0000_0013, taken: 1'b0};
        redirect = '0;
        exec_info = '0;
        mem_info = '0;
        trap = 1'b0;
        backend_stall = 1'b0;
        writeback = '0;
    endtask

    task automatic decode(input logic [31:0] pc, input logic [31:0] instr);
        fetch = '{pc: pc, instr: instr, taken: 1'b0};
        next_cycle();
    endtask

    function automatic logic [31:0] random_pc();
        seed = xorshift(seed);
        return {seed[31:2], 2'b00};
    endfunction

    task automatic check_ctrl(input string name, input logic [31:0] pc, input int size,
                              input logic [4:0] waddr, input logic [4:0] raddr1,
                              input logic [31:0] imm);
        check({name, " valid"}, 32'd1, 32'(q.ctrl.valid));
        check({name, " exception"}, 32'd0, 32'(q.exception));
        check({name, " pc"}, pc, q.pc);
        check({name, " npc"}, pc + 32'(size), q.npc);
        check({name, " waddr"}, 32'(waddr), 32'(q.ctrl.waddr));
        check({name, " raddr1"}, 32'(raddr1), 32'(q.ctrl.raddr1));
        check({name, " imm"}, imm, q.ctrl.imm);
    endtask

    task automatic check_exception(input string name, input logic [31:0] instr,
                                   input logic [3:0] cause);
        decode(random_pc(), instr);
        check({name, " exception"}, 32'd1, 32'(q.exception));
        check({name, " ecause"}, 32'(cause), 32'(q.ecause));
        check({name, " etval"}, instr, q.etval);
    endtask

    task automatic rv32i_test();
        logic [31:0] pc;
        pc = random_pc();
        decode(pc, enc_i(12'hffd, 5'd6, 3'b000, 5'd5, op_imm));
        check_ctrl("addi", pc, 4, 5'd5, 5'd6, 32'hffff_fffd);
        check("addi alu", 32'(alu_add), 32'(q.ctrl.alu_op));
        decode(pc, enc_r(7'h20, 5'd9, 5'd8, 3'b000, 5'd7));
        check_ctrl("sub", pc, 4, 5'd7, 5'd8, 32'h0);
        check("sub alu", 32'(alu_sub), 32'(q.ctrl.alu_op));
        check("sub raddr2", 32'd9, 32'(q.ctrl.raddr2));
        decode(pc, enc_i(12'd16, 5'd11, 3'b010, 5'd10, op_load));
        check_ctrl("lw", pc, 4, 5'd10, 5'd11, 32'd16);
        check("lw load", 32'd1, 32'(q.ctrl.load));
        check("lw lsu", 32'(lsu_lw), 32'(q.ctrl.lsu_op));
        decode(pc, enc_s(12'hff8, 5'd12, 5'd13, 3'b010));
        check_ctrl("sw", pc, 4, 5'd24, 5'd13, 32'hffff_fff8);
        check("sw store", 32'd1, 32'(q.ctrl.store));
        check("sw raddr2", 32'd12, 32'(q.ctrl.raddr2));
        decode(pc, enc_b(13'h1ff0, 5'd2, 5'd1, 3'b001));
        check("bne branch", 32'd1, 32'(q.ctrl.branch));
        check("bne bcu", 32'(bcu_bne), 32'(q.ctrl.bcu_op));
        check("bne imm", 32'hffff_fff0, q.ctrl.imm);
        // The rs1 field of this lui encoding holds x8.
        decode(pc, {20'h12345, 5'd3, op_lui});
        check_ctrl("lui", pc, 4, 5'd3, 5'd8, 32'h1234_5000);
        check("lui flag", 32'd1, 32'(q.ctrl.lui));
        decode(pc, enc_j(21'h800, 5'd0));
        check("jal imm", 32'h800, q.ctrl.imm);
        check("jal flag", 32'd1, 32'(q.ctrl.jal));
        decode(pc, 32'h0ff0_000f);
        check("fence flag", 32'd1, 32'(q.ctrl.fence));
        check("fence exception", 32'd0, 32'(q.exception));
        check_exception("undefined", 32'hffff_ffff, except_illegal_instruction);
        check_exception("ebreak", 32'h0010_0073, except_breakpoint);
        check_exception("ecall", 32'h0000_0073, except_env_call);
    endtask

    task automatic rvc_test();
        logic [31:0] pc;
        pc = random_pc() + 32'd2;
        decode(pc, 32'h0000_0495);
        check_ctrl("c.addi", pc, 2, 5'd9, 5'd9, 32'd5);
        decode(pc, 32'h0000_557d);
        check_ctrl("c.li", pc, 2, 5'd10, 5'd0, 32'hffff_ffff);
        decode(pc, 32'h0000_85b2);
        check_ctrl("c.mv", pc, 2, 5'd11, 5'd0, 32'h0);
        check("c.mv raddr2", 32'd12, 32'(q.ctrl.raddr2));
        decode(pc, 32'h0000_95b2);
        check_ctrl("c.add", pc, 2, 5'd11, 5'd11, 32'h0);
        decode(pc, 32'h0000_4144);
        check_ctrl("c.lw", pc, 2, 5'd9, 5'd10, 32'd4);
        check("c.lw load", 32'd1, 32'(q.ctrl.load));
        decode(pc, 32'h0000_c504);
        check("c.sw store", 32'd1, 32'(q.ctrl.store));
        check("c.sw raddr2", 32'd9, 32'(q.ctrl.raddr2));
        check("c.sw imm", 32'd8, q.ctrl.imm);
        decode(pc, 32'h0000_a011);
        check_ctrl("c.j", pc, 2, 5'd0, 5'd0, 32'd4);
        check("c.j jal", 32'd1, 32'(q.ctrl.jal));
        decode(pc, 32'h0000_8082);
        check_ctrl("c.jr", pc, 2, 5'd0, 5'd1, 32'h0);
        check("c.jr hints", 32'b0100, 32'({q.return_push, q.return_pop, q.jump_uncond,
                                           q.jump_rest}));
        decode(pc, 32'h0000_9282);
        check_ctrl("c.jalr", pc, 2, 5'd1, 5'd5, 32'h0);
        check("c.jalr jalr", 32'd1, 32'(q.ctrl.jalr));
        check_exception("c.ebreak", 32'h0000_9002, except_breakpoint);
        check_exception("c.unsupported", 32'h0000_0000, except_illegal_instruction);
    endtask

    task automatic hints_test();
        logic [4:0] regs_list [4];
        logic [3:0] hints;
        regs_list = '{5'd0, 5'd1, 5'd5, 5'd7};
        for (int i = 0; i < 4; i++) begin
            decode(random_pc(), enc_j(21'h40, regs_list[i]));
            hints = {q.return_push, q.return_pop, q.jump_uncond, q.jump_rest};
            check($sformatf("jal x%0d hints", regs_list[i]),
                  32'(expected_hints(1'b1, regs_list[i], 5'd0)), 32'(hints));
            for (int j = 0; j < 4; j++) begin
                decode(random_pc(), enc_i(12'h0, regs_list[j], 3'b000, regs_list[i], op_jalr));
                hints = {q.return_push, q.return_pop, q.jump_uncond, q.jump_rest};
                check($sformatf("jalr x%0d, x%0d hints", regs_list[i], regs_list[j]),
                      32'(expected_hints(1'b0, regs_list[i], regs_list[j])), 32'(hints));
            end
        end
    endtask

    task automatic stall_test();
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        pc_a = random_pc();
        pc_b = random_pc();
        exec_info = '{load: 1'b1, fence: 1'b0, waddr: 5'd6};
        decode(pc_a, enc_r(7'h00, 5'd8, 5'd6, 3'b000, 5'd7));
        check("load-use stall", 32'd1, 32'(q.stall));
        check("load-use bubble", 32'd0, 32'(q.ctrl.valid));
        exec_info = '0;
        decode(pc_b, 32'h0000_0013);
        check("replay pc", pc_a, q.pc);
        check("replay raddr1", 32'd6, 32'(q.ctrl.raddr1));
        check("replay stall", 32'd0, 32'(q.stall));
        next_cycle();
        check("after replay pc", pc_b, q.pc);
        mem_info.fence = 1'b1;
        decode(pc_a, 32'h0000_0013);
        check("fence stall", 32'd1, 32'(q.stall));
        mem_info = '0;
        decode(pc_b, 32'h0000_0013);
        check("fence replay pc", pc_a, q.pc);
        backend_stall = 1'b1;
        decode(pc_b, enc_i(12'd1, 5'd2, 3'b000, 5'd3, op_imm));
        check("backend hold pc", pc_a, q.pc);
        backend_stall = 1'b0;
        next_cycle();
        check("backend release pc", pc_b, q.pc);
    endtask

    task automatic clear_test();
        logic [31:0] pc;
        for (int k = 0; k < 5; k++) begin
            pc = random_pc();
            fetch = '{pc: pc, instr: 32'hffff_ffff, taken: (k == 1) || (k == 3)};
            trap = (k == 0);
            redirect.jump = (k == 2) || (k == 3);
            redirect.address = pc + 32'd8; // Only matters for the wrong target.
            redirect.fence = (k == 4);
            next_cycle();
            check($sformatf("clear case %0d clear", k), 32'd1, 32'(q.clear));
            check($sformatf("clear case %0d stall", k), 32'd0, 32'(q.stall));
            check($sformatf("clear case %0d exception", k), 32'd0, 32'(q.exception));
            check($sformatf("clear case %0d valid", k), 32'd0, 32'(q.ctrl.valid));
        end
        pc = random_pc();
        trap = 1'b0;
        redirect = '{jump: 1'b1, address: pc, fence: 1'b0};
        fetch = '{pc: pc, instr: 32'h0000_0013, taken: 1'b1};
        next_cycle();
        check("right target clear", 32'd0, 32'(q.clear));
        check("right target taken", 32'd1, 32'(q.taken));
        idle_inputs();
    endtask

    task automatic register_test();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        seed = xorshift(seed);
        v1 = seed;
        seed = xorshift(seed);
        v2 = seed;
        seed = xorshift(seed);
        v3 = seed;
        writeback = '{wren: 1'b1, waddr: 5'd3, wdata: v1};
        next_cycle();
        writeback = '{wren: 1'b1, waddr: 5'd4, wdata: v2};
        next_cycle();
        writeback = '0;
        decode(random_pc(), enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd5));
        check("read x3", v1, rdata1);
        check("read x4", v2, rdata2);
        check("read aligned raddr1", 32'd3, 32'(q.ctrl.raddr1));
        writeback = '{wren: 1'b1, waddr: 5'd0, wdata: v3};
        decode(random_pc(), enc_r(7'h00, 5'd4, 5'd0, 3'b000, 5'd5));
        check("read x0", 32'h0, rdata1);
        writeback = '{wren: 1'b1, waddr: 5'd6, wdata: v3};
        decode(random_pc(), enc_r(7'h00, 5'd4, 5'd6, 3'b000, 5'd7));
        check("forward x6", v3, rdata1);
        check("forward x4", v2, rdata2);
        writeback = '0;
    endtask

    initial begin
        idle_inputs();
        reset = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        check("reset valid", 32'd1, 32'(q.ctrl.valid));
        check("reset stall", 32'd0, 32'(q.stall));
        check("reset clear", 32'd0, 32'(q.clear));
        reset = 1'b1;
        rv32i_test();
        rvc_test();
        hints_test();
        stall_test();
        clear_test();
        register_test();
        $display("Checks done with %0d errors.", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/decode_pkg.sv
src/rv_decoder.sv
src/rvc_decoder.sv
src/decode_stage.sv
src/register_file.sv
src/decode_top.sv
bench/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module decode_tb -o decode_sim
output=$(./obj_dir/decode_sim)
echo "$output"
echo "$output" | grep -q "Simulation PASSED"

// ==== src/decode_pkg.sv ====
package decode_pkg;

    localparam int xlen = 32;

    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_fence = 7'b0001111;
    localparam logic [6:0] op_system = 7'b1110011;

    // Machine cause codes.
    localparam logic [3:0] except_illegal_instruction = 4'd2;
    localparam logic [3:0] except_breakpoint = 4'd3;
    localparam logic [3:0] except_env_call = 4'd11;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_type;

    typedef enum logic [2:0] {
        bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
    } bcu_op_type;

    typedef enum logic [2:0] {
        lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw
    } lsu_op_type;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0] instr;
        logic taken; // Fetch predicted a taken jump.
    } fetch_type;

    typedef struct packed {
        logic jump;
        logic [xlen-1:0] address;
        logic fence;
    } redirect_type;

    typedef struct packed {
        logic load;
        logic fence;
        logic [4:0] waddr;
    } stage_info_type;

    typedef struct packed {
        logic wren;
        logic [4:0] waddr;
        logic [xlen-1:0] wdata;
    } writeback_type;

    typedef struct packed {
        logic rden1;
        logic rden2;
        logic [4:0] raddr1;
        logic [4:0] raddr2;
    } register_read_type;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] imm;
        logic [4:0] waddr;
        logic [4:0] raddr1;
        logic [4:0] raddr2;
        logic wren;
        logic rden1;
        logic rden2;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic fence;
        logic ecall;
        logic ebreak;
        alu_op_type alu_op;
        bcu_op_type bcu_op;
        lsu_op_type lsu_op;
    } decoder_out_type;

    typedef struct packed {
        decoder_out_type ctrl;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic taken;
        logic return_push;
        logic return_pop;
        logic jump_uncond;
        logic jump_rest;
        logic exception;
        logic [3:0] ecause;
        logic [xlen-1:0] etval;
        logic stall;
        logic clear;
    } decode_out_type;

    localparam decoder_out_type init_decoder_out = '{
        valid: 1'b1, alu_op: alu_add, bcu_op: bcu_beq, lsu_op: lsu_lb, default: '0
    };

    // Valid is set so that the reset value does not read as an illegal instruction.
    localparam decode_out_type init_decode_out = '{ctrl: init_decoder_out, default: '0};

endpackage

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input logic clock,
    input logic reset,
    input decode_pkg::fetch_type fetch,
    input decode_pkg::redirect_type redirect,
    input decode_pkg::stage_info_type exec_info,
    input decode_pkg::stage_info_type mem_info,
    input logic trap,
    input logic backend_stall,
    output logic [31:0] instr,
    input decode_pkg::decoder_out_type base_out,
    input decode_pkg::decoder_out_type compressed_out,
    output decode_pkg::register_read_type register_read,
    output decode_pkg::decode_out_type q
);
    import decode_pkg::*;

    fetch_type held;
    fetch_type current;
    decoder_out_type ctrl;
    decode_out_type d;
    logic compressed;
    logic link_waddr;
    logic link_raddr1;

    // A stalled instruction is decoded again from the held copy.
    assign current = q.stall ? held : fetch;
    assign instr = current.instr;
    assign compressed = (current.instr[1:0] != 2'b11);
    assign ctrl = compressed ? compressed_out : base_out;

    assign link_waddr = (ctrl.waddr == 5'd1) || (ctrl.waddr == 5'd5);
    assign link_raddr1 = (ctrl.raddr1 == 5'd1) || (ctrl.raddr1 == 5'd5);

    assign register_read.rden1 = ctrl.rden1;
    assign register_read.rden2 = ctrl.rden2;
    assign register_read.raddr1 = ctrl.raddr1;
    assign register_read.raddr2 = ctrl.raddr2;

    always_comb begin
        d = init_decode_out;
        d.ctrl = ctrl;
        d.pc = current.pc;
        d.npc = current.pc + (compressed ? 32'd2 : 32'd4);
        d.taken = current.taken;

        if (ctrl.jal) begin
            if (link_waddr) begin
                d.return_push = 1'b1;
            end else if (ctrl.waddr == 5'd0) begin
                d.jump_uncond = 1'b1;
            end else begin
                d.jump_rest = 1'b1;
            end
        end

        if (ctrl.jalr) begin
            if (!link_waddr && link_raddr1) begin
                d.return_pop = 1'b1;
            end else if (link_waddr) begin
                d.return_push = 1'b1; // Pop as well when the two links differ.
                d.return_pop = link_raddr1 && (ctrl.waddr != ctrl.raddr1);
            end else begin
                d.jump_rest = 1'b1;
            end
        end

        d.exception = !ctrl.valid || ctrl.ebreak || ctrl.ecall;
        if (!ctrl.valid) begin
            d.ecause = except_illegal_instruction;
        end else if (ctrl.ebreak) begin
            d.ecause = except_breakpoint;
        end else if (ctrl.ecall) begin
            d.ecause = except_env_call;
        end
        if (d.exception) begin
            d.etval = compressed ? {16'b0, current.instr[15:0]} : current.instr;
        end

        d.clear = trap || redirect.fence || (redirect.jump != current.taken) ||
                  (redirect.jump && current.taken && redirect.address != current.pc);

        d.stall = exec_info.fence || mem_info.fence ||
                  (exec_info.load && ((ctrl.rden1 && exec_info.waddr == ctrl.raddr1) ||
                                      (ctrl.rden2 && exec_info.waddr == ctrl.raddr2)));

        // Both a stall and a clear turn the slot into a bubble.
        if (d.stall || d.clear) begin
            d.ctrl.valid = 1'b0;
            d.ctrl.wren = 1'b0;
            d.ctrl.rden1 = 1'b0;
            d.ctrl.rden2 = 1'b0;
            d.ctrl.lui = 1'b0;
            d.ctrl.auipc = 1'b0;
            d.ctrl.jal = 1'b0;
            d.ctrl.jalr = 1'b0;
            d.ctrl.branch = 1'b0;
            d.ctrl.load = 1'b0;
            d.ctrl.store = 1'b0;
            d.ctrl.fence = 1'b0;
            d.ctrl.ecall = 1'b0;
            d.ctrl.ebreak = 1'b0;
            d.taken = 1'b0;
            d.return_push = 1'b0;
            d.return_pop = 1'b0;
            d.jump_uncond = 1'b0;
            d.jump_rest = 1'b0;
            d.exception = 1'b0;
        end
        if (d.clear) begin
            d.stall = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            q <= init_decode_out;
        end else if (!backend_stall) begin
            q <= d;
        end
    end

    always_ff @(posedge clock) begin
        if (!backend_stall) begin
            held <= current;
        end
    end

    assert property (@(posedge clock) disable iff (!reset) !(q.stall && q.clear))
        else $error("decode stage reports stall and clear together");

    // A bubble taken in must leave the stage with no live control or trap.
    assert property (@(posedge clock) disable iff (!reset)
        (d.stall || d.clear) && !backend_stall |=>
            !q.ctrl.valid && !q.ctrl.wren && !q.ctrl.store && !q.exception)
        else $error("decode bubble carries live controls");

endmodule

// ==== src/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input logic clock,
    input logic reset,
    input decode_pkg::fetch_type fetch,
    input decode_pkg::redirect_type redirect,
    input decode_pkg::stage_info_type exec_info,
    input decode_pkg::stage_info_type mem_info,
    input logic trap,
    input logic backend_stall,
    input decode_pkg::writeback_type writeback,
    output decode_pkg::decode_out_type q,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);
    import decode_pkg::*;

    logic [31:0] instr;
    decoder_out_type base_out;
    decoder_out_type compressed_out;
    register_read_type register_read;

    decode_stage decode_stage_inst (
        .clock(clock),
        .reset(reset),
        .fetch(fetch),
        .redirect(redirect),
        .exec_info(exec_info),
        .mem_info(mem_info),
        .trap(trap),
        .backend_stall(backend_stall),
        .instr(instr),
        .base_out(base_out),
        .compressed_out(compressed_out),
        .register_read(register_read),
        .q(q)
    );

    rv_decoder rv_decoder_inst (
        .instr(instr),
        .result(base_out)
    );

    rvc_decoder rvc_decoder_inst (
        .instr(instr[15:0]),
        .result(compressed_out)
    );

    // The read port holds with the stage so rdata stays aligned with q.
    register_file register_file_inst (
        .clock(clock),
        .reset(reset),
        .hold(backend_stall),
        .read(register_read),
        .writeback(writeback),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input logic clock,
    input logic reset,
    input logic hold,
    input decode_pkg::register_read_type read,
    input decode_pkg::writeback_type writeback,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);
    import decode_pkg::*;

    logic [xlen-1:0] regs [0:31];

    // Reads see a write to the same register in the same cycle.
    function automatic logic [xlen-1:0] bypass(input logic [4:0] addr,
                                               input logic [xlen-1:0] stored,
                                               input writeback_type wb);
        if (addr == 5'd0) return '0;
        if (wb.wren && wb.waddr == addr) return wb.wdata;
        return stored;
    endfunction

    always_ff @(posedge clock) begin
        if (writeback.wren && writeback.waddr != 5'd0) begin
            regs[writeback.waddr] <= writeback.wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rdata1 <= '0;
            rdata2 <= '0;
        end else if (!hold) begin
            if (read.rden1) rdata1 <= bypass(read.raddr1, regs[read.raddr1], writeback);
            if (read.rden2) rdata2 <= bypass(read.raddr2, regs[read.raddr2], writeback);
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        writeback.wren && writeback.waddr == 5'd0 && !hold &&
        read.rden1 && read.raddr1 == 5'd0 |=> rdata1 == '0)
        else $error("write to x0 became visible");

endmodule

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input logic [31:0] instr,
    output decode_pkg::decoder_out_type result
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    function automatic alu_op_type alu_select(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b011: return alu_sltu;
            3'b100: return alu_xor;
            3'b101: return alt ? alu_sra : alu_srl;
            3'b110: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        result = init_decoder_out;
        result.waddr = instr[11:7];
        result.raddr1 = instr[19:15];
        result.raddr2 = instr[24:20];
        case (opcode)
            op_lui, op_auipc: begin
                result.imm = imm_u;
                result.wren = 1'b1;
                result.lui = (opcode == op_lui);
                result.auipc = (opcode == op_auipc);
            end
            op_jal: begin
                result.imm = imm_j;
                result.wren = 1'b1;
                result.jal = 1'b1;
            end
            op_jalr: begin
                result.imm = imm_i;
                result.wren = 1'b1;
                result.rden1 = 1'b1;
                result.jalr = 1'b1;
                result.valid = (funct3 == 3'b000);
            end
            op_branch: begin
                result.imm = imm_b;
                result.rden1 = 1'b1;
                result.rden2 = 1'b1;
                result.branch = 1'b1;
                case (funct3)
                    3'b000: result.bcu_op = bcu_beq;
                    3'b001: result.bcu_op = bcu_bne;
                    3'b100: result.bcu_op = bcu_blt;
                    3'b101: result.bcu_op = bcu_bge;
                    3'b110: result.bcu_op = bcu_bltu;
                    3'b111: result.bcu_op = bcu_bgeu;
                    default: result.valid = 1'b0;
                endcase
            end
            op_load: begin
                result.imm = imm_i;
                result.wren = 1'b1;
                result.rden1 = 1'b1;
                result.load = 1'b1;
                case (funct3)
                    3'b000: result.lsu_op = lsu_lb;
                    3'b001: result.lsu_op = lsu_lh;
                    3'b010: result.lsu_op = lsu_lw;
                    3'b100: result.lsu_op = lsu_lbu;
                    3'b101: result.lsu_op = lsu_lhu;
                    default: result.valid = 1'b0;
                endcase
            end
            op_store: begin
                result.imm = imm_s;
                result.rden1 = 1'b1;
                result.rden2 = 1'b1;
                result.store = 1'b1;
                case (funct3)
                    3'b000: result.lsu_op = lsu_sb;
                    3'b001: result.lsu_op = lsu_sh;
                    3'b010: result.lsu_op = lsu_sw;
                    default: result.valid = 1'b0;
                endcase
            end
            op_imm: begin
                result.imm = imm_i;
                result.wren = 1'b1;
                result.rden1 = 1'b1;
                result.alu_op = alu_select(funct3, (funct3 == 3'b101) && funct7[5]);
                // Shift amounts only take the low five bits of the immediate.
                if (funct3 == 3'b001) begin
                    result.valid = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    result.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            op_reg: begin
                result.wren = 1'b1;
                result.rden1 = 1'b1;
                result.rden2 = 1'b1;
                result.alu_op = alu_select(funct3, funct7[5]);
                result.valid = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            op_fence: begin
                result.fence = 1'b1;
                result.valid = (funct3 == 3'b000);
            end
            op_system: begin
                result.ecall = (instr == 32'h0000_0073);
                result.ebreak = (instr == 32'h0010_0073);
                result.valid = result.ecall || result.ebreak; // No CSR access here.
            end
            default: result.valid = 1'b0;
        endcase
    end

endmodule

// ==== src/rvc_decoder.sv ====
`timescale 1ns/1ps

module rvc_decoder (
    input logic [15:0] instr,
    output decode_pkg::decoder_out_type result
);
    import decode_pkg::*;

    logic [4:0] rd;
    logic [4:0] rs2;
    logic [4:0] rd_short;
    logic [4:0] rs1_short;
    logic [31:0] imm_addi;
    logic [31:0] imm_lw;
    logic [31:0] imm_j;

    assign rd = instr[11:7];
    assign rs2 = instr[6:2];
    assign rd_short = {2'b01, instr[4:2]}; // Three-bit fields cover x8 to x15.
    assign rs1_short = {2'b01, instr[9:7]};

    assign imm_addi = {{26{instr[12]}}, instr[12], instr[6:2]};
    assign imm_lw = {25'b0, instr[5], instr[12:10], instr[6], 2'b00};
    assign imm_j = {{20{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6],
                    instr[7], instr[2], instr[11], instr[5:3], 1'b0};

    always_comb begin
        result = init_decoder_out;
        result.valid = 1'b0;
        case ({instr[1:0], instr[15:13]})
            5'b01_000, 5'b01_010: begin // C.ADDI and C.LI.
                result.valid = 1'b1;
                result.imm = imm_addi;
                result.waddr = rd;
                result.raddr1 = instr[14] ? 5'd0 : rd;
                result.wren = 1'b1;
                result.rden1 = 1'b1;
            end
            5'b00_010: begin // C.LW.
                result.valid = 1'b1;
                result.imm = imm_lw;
                result.waddr = rd_short;
                result.raddr1 = rs1_short;
                result.wren = 1'b1;
                result.rden1 = 1'b1;
                result.load = 1'b1;
                result.lsu_op = lsu_lw;
            end
            5'b00_110: begin // C.SW.
                result.valid = 1'b1;
                result.imm = imm_lw;
                result.raddr1 = rs1_short;
                result.raddr2 = rd_short;
                result.rden1 = 1'b1;
                result.rden2 = 1'b1;
                result.store = 1'b1;
                result.lsu_op = lsu_sw;
            end
            5'b01_101: begin
                result.valid = 1'b1;
                result.imm = imm_j;
                result.wren = 1'b1;
                result.jal = 1'b1;
            end
            5'b10_100: begin
                if (rs2 == 5'd0 && !(instr[12] == 1'b0 && rd == 5'd0)) begin
                    // C.EBREAK when rs1 is zero, otherwise C.JR or C.JALR.
                    result.valid = 1'b1;
                    result.ebreak = instr[12] && rd == 5'd0;
                    result.jalr = !result.ebreak;
                    result.waddr = {4'b0, instr[12]};
                    result.raddr1 = rd;
                    result.wren = result.jalr;
                    result.rden1 = result.jalr;
                end else if (rs2 != 5'd0) begin
                    // C.MV adds to x0, C.ADD adds to rd.
                    result.valid = 1'b1;
                    result.waddr = rd;
                    result.raddr1 = instr[12] ? rd : 5'd0;
                    result.raddr2 = rs2;
                    result.wren = 1'b1;
                    result.rden1 = 1'b1;
                    result.rden2 = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule
